// ==== bin_coder.f ====
+incdir+design
design/coder_types_pkg.sv
design/ctx_mem_pkg.sv
design/ctx_mem_if.sv
design/ctx_store.sv
design/ctx_modeler.sv
design/ctx_host_port.sv
design/range_encoder.sv
design/bin_coder_top.sv
tb/clk_gen.sv
tb/tb_bin_coder.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the bin coder testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -j 0 -Wno-fatal \
  --timescale 1ns/1ps \
  --top-module tb_bin_coder \
  --Mdir "$build_dir" \
  -o sim_bin_coder \
  -f bin_coder.f

# a failing run stops on $fatal, the log decides the result
"./$build_dir/sim_bin_coder" | tee "$log_file" || true

if grep -q "TEST RESULT: PASS" "$log_file"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $log_file"
  exit 1
fi

// ==== tb/tb_bin_coder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bin_coder_consts.svh"

module tb_bin_coder;

  localparam int WAIT_LIMIT = 4000; // cycles before any wait gives up

  logic                      clk;
  logic                      rst_n;
  logic                      bin_valid;
  logic                      bin_ready;
  logic                      bin_sym;
  coder_types_pkg::ctx_idx_t bin_ctx;
  logic                      host_valid;
  logic                      host_ready;
  logic                      host_write;
  coder_types_pkg::ctx_idx_t host_ctx;
  coder_types_pkg::prob_t    host_wprob;
  logic                      host_rvalid;
  coder_types_pkg::prob_t    host_rprob;
  coder_types_pkg::byte_t    out_byte;
  logic                      out_valid;
  logic                      out_ready = 1'b0; // driven by the sink process only

  coder_types_pkg::prob_t       model_prob [`CTX_COUNT]; // expected context table
  coder_types_pkg::coder_word_t model_low;
  coder_types_pkg::coder_word_t model_range;
  coder_types_pkg::byte_t       exp_bytes [$];  // coded, not yet seen at the output
  int                           bytes_seen = 0;
  logic                         stall_mode = 1'b0; // allow long out_ready low stretches
  int                           stall_left = 0;
  logic                         held_valid = 1'b0; // byte refused at the last edge
  coder_types_pkg::byte_t       held_byte;

  clk_gen u_clk (
    .clk (clk)
  );

  bin_coder_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .bin_valid   (bin_valid),
    .bin_ready   (bin_ready),
    .bin_sym     (bin_sym),
    .bin_ctx     (bin_ctx),
    .host_valid  (host_valid),
    .host_ready  (host_ready),
    .host_write  (host_write),
    .host_ctx    (host_ctx),
    .host_wprob  (host_wprob),
    .host_rvalid (host_rvalid),
    .host_rprob  (host_rprob),
    .out_byte    (out_byte),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
  );

  task automatic stop_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic abort_run(input string why);
    $display("ERROR at %0t: %s", $time, why);
    stop_run();
  endtask

  task automatic check_byte(input string name, input coder_types_pkg::byte_t got,
                            input coder_types_pkg::byte_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s is 0x%02h, expected 0x%02h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_prob(input string name, input coder_types_pkg::prob_t got,
                            input coder_types_pkg::prob_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  // p(one) after one more symbol, kept inside the clamp bounds
  function automatic coder_types_pkg::prob_t adapt_prob(input coder_types_pkg::prob_t p,
                                                        input logic sym);
    int unsigned q;
    q = 32'(p);
    if (sym) q = q + ((32'd4096 - q) >> `ADAPT_SHIFT);
    else q = q - (q >> `ADAPT_SHIFT);
    if (q < 32'(`PROB_MIN)) q = 32'(`PROB_MIN);
    if (q > 32'(`PROB_MAX)) q = 32'(`PROB_MAX);
    return coder_types_pkg::prob_t'(q);
  endfunction

  // interval update and renormalization, bytes go to the expected queue
  task automatic code_symbol(input logic sym, input coder_types_pkg::prob_t p);
    logic [63:0] split;
    split = (64'(model_range) * 64'(p)) >> `PROB_BITS;
    if (sym) begin
      model_low   = model_low + (model_range - split[31:0]); // carry out of low is dropped
      model_range = split[31:0];
    end else begin
      model_range = model_range - split[31:0];
    end
    while (model_range < `RENORM_MIN) begin
      exp_bytes.push_back(model_low[31:24]);
      model_low   = model_low << 8;
      model_range = model_range << 8;
    end
  endtask

  task automatic send_bin(input logic sym, input coder_types_pkg::ctx_idx_t c);
    int n;
    n = 0;
    while (!bin_ready) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) abort_run("bin_ready stayed low, the modeler never took a bin");
    end
    bin_valid = 1'b1;
    bin_sym   = sym;
    bin_ctx   = c;
    code_symbol(sym, model_prob[c]); // coded with the value before adaptation
    model_prob[c] = adapt_prob(model_prob[c], sym);
    @(negedge clk); // accepted at the edge in between
    bin_valid = 1'b0;
  endtask

  task automatic write_context(input coder_types_pkg::ctx_idx_t c,
                               input coder_types_pkg::prob_t p);
    int n;
    n = 0;
    while (!host_ready) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) abort_run("host port stayed busy before a write");
    end
    host_valid = 1'b1;
    host_write = 1'b1;
    host_ctx   = c;
    host_wprob = p;
    @(negedge clk);
    host_valid = 1'b0;
    n = 0;
    while (!host_ready) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) abort_run("host write never completed");
    end
  endtask

  task automatic read_context(input coder_types_pkg::ctx_idx_t c,
                              input coder_types_pkg::prob_t exp);
    int n;
    n = 0;
    while (!host_ready) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) abort_run("host port stayed busy before a read");
    end
    host_valid = 1'b1;
    host_write = 1'b0;
    host_ctx   = c;
    @(negedge clk);
    host_valid = 1'b0;
    n = 0;
    while (!host_rvalid) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) abort_run("host_rvalid never pulsed for a read");
    end
    check_prob("host_rprob", host_rprob, exp);
  endtask

  // wait until every expected byte is out and the modeler is idle again
  task automatic drain_bytes();
    int n;
    n = 0;
    while (exp_bytes.size() != 0 || !bin_ready) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) abort_run("expected coded bytes never came out");
    end
  endtask

  // byte sink, random back-pressure with optional long stalls
  always @(negedge clk) begin
    if (stall_left > 0) begin
      out_ready = 1'b0;
      stall_left--;
    end else if (stall_mode && $urandom_range(7, 0) == 0) begin
      out_ready  = 1'b0;
      stall_left = $urandom_range(90, 20);
    end else begin
      out_ready = ($urandom_range(3, 0) != 0); // mostly ready
    end
  end

  // output monitor, one byte per valid and ready edge
  always @(posedge clk) begin
    if (rst_n) begin
      if (held_valid) begin
        if (!out_valid) abort_run("out_valid dropped before the held byte was taken");
        else check_byte("out_byte", out_byte, held_byte); // must not move while held
      end
      if (out_valid && out_ready) begin
        if (exp_bytes.size() == 0) abort_run("a coded byte came out that the model lacks");
        else begin
          check_byte("out_byte", out_byte, exp_bytes.pop_front());
          bytes_seen++;
        end
      end
      held_valid = out_valid && !out_ready;
      held_byte  = out_byte;
    end
  end

  initial begin
    int                        i;
    int                        j;
    int                        k;
    coder_types_pkg::ctx_idx_t c;
    coder_types_pkg::ctx_idx_t hc;
    coder_types_pkg::prob_t    p;
    rst_n      = 1'b0;
    bin_valid  = 1'b0;
    bin_sym    = 1'b0;
    bin_ctx    = '0;
    host_valid = 1'b0;
    host_write = 1'b0;
    host_ctx   = '0;
    host_wprob = '0;
    void'($urandom(93)); // single seed for the run
    model_low   = '0;
    model_range = '1;
    repeat (5) @(posedge clk); // five full cycles in reset
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (!bin_ready || !host_ready || out_valid || host_rvalid)
      abort_run("handshake outputs are not at their reset values");

    // load all contexts, read them back unchanged
    for (i = 0; i < `CTX_COUNT; i++) begin
      c = coder_types_pkg::ctx_idx_t'(i);
      p = coder_types_pkg::prob_t'($urandom_range(4095, 1)); // zero would collapse range
      model_prob[c] = p;
      write_context(c, p);
    end
    for (i = 0; i < `CTX_COUNT; i++) begin
      c = coder_types_pkg::ctx_idx_t'(i);
      read_context(c, model_prob[c]);
    end

    // random bins, then the adapted table
    for (i = 0; i < 400; i++)
      send_bin($urandom_range(1, 0) == 1, coder_types_pkg::ctx_idx_t'($urandom_range(63, 0)));
    drain_bytes();
    for (i = 0; i < `CTX_COUNT; i++) begin
      c = coder_types_pkg::ctx_idx_t'(i);
      read_context(c, model_prob[c]);
    end

    stall_mode = 1'b1; // long back-pressure stretches
    for (i = 0; i < 200; i++)
      send_bin($urandom_range(1, 0) == 1, coder_types_pkg::ctx_idx_t'($urandom_range(63, 0)));
    drain_bytes();
    stall_mode = 1'b0;

    // host reads race the modeler, bins use the lower half only
    fork
      begin
        for (j = 0; j < 150; j++)
          send_bin($urandom_range(1, 0) == 1,
                   coder_types_pkg::ctx_idx_t'($urandom_range(31, 0)));
      end
      begin
        for (k = 0; k < 60; k++) begin
          hc = coder_types_pkg::ctx_idx_t'($urandom_range(63, 32));
          read_context(hc, model_prob[hc]);
        end
      end
    join
    drain_bytes();

    // saturate two contexts at opposite bounds
    repeat (300) send_bin(1'b1, coder_types_pkg::ctx_idx_t'(5));
    repeat (300) send_bin(1'b0, coder_types_pkg::ctx_idx_t'(6));
    drain_bytes();
    read_context(coder_types_pkg::ctx_idx_t'(5), `PROB_MAX);
    read_context(coder_types_pkg::ctx_idx_t'(6), `PROB_MIN);
    for (i = 0; i < `CTX_COUNT; i++) begin
      c = coder_types_pkg::ctx_idx_t'(i);
      read_context(c, model_prob[c]);
    end

    if (bytes_seen > 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      abort_run("no coded byte was ever observed");
    end
  end

endmodule

`default_nettype wire

// ==== tb/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// free running testbench clock, 4 ns period
module clk_gen (
  output logic clk
);

  always begin
    clk = 1'b0;
    #2;
    clk = 1'b1;
    #2;
  end

endmodule

`default_nettype wire

// ==== design/bin_coder_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bin_coder_top (
  input  logic                      clk,
  input  logic                      rst_n,
  // bins in
  input  logic                      bin_valid,
  output logic                      bin_ready,
  input  logic                      bin_sym,
  input  coder_types_pkg::ctx_idx_t bin_ctx,
  // host context access
  input  logic                      host_valid,
  output logic                      host_ready,
  input  logic                      host_write,
  input  coder_types_pkg::ctx_idx_t host_ctx,
  input  coder_types_pkg::prob_t    host_wprob,
  output logic                      host_rvalid,
  output coder_types_pkg::prob_t    host_rprob,
  // coded bytes out
  output coder_types_pkg::byte_t    out_byte,
  output logic                      out_valid,
  input  logic                      out_ready
);

  ctx_mem_if mdl_bus ();
  ctx_mem_if host_bus ();

  logic                   enc_valid;
  logic                   enc_ready;
  logic                   enc_sym;
  coder_types_pkg::prob_t enc_prob;

  ctx_store u_store (
    .clk   (clk),
    .rst_n (rst_n),
    .mdl   (mdl_bus),
    .host  (host_bus)
  );

  ctx_modeler u_modeler (
    .clk       (clk),
    .rst_n     (rst_n),
    .bin_valid (bin_valid),
    .bin_sym   (bin_sym),
    .bin_ctx   (bin_ctx),
    .bin_ready (bin_ready),
    .mem       (mdl_bus),
    .enc_valid (enc_valid),
    .enc_sym   (enc_sym),
    .enc_prob  (enc_prob),
    .enc_ready (enc_ready)
  );

  ctx_host_port u_host (
    .clk         (clk),
    .rst_n       (rst_n),
    .host_valid  (host_valid),
    .host_write  (host_write),
    .host_ctx    (host_ctx),
    .host_wprob  (host_wprob),
    .host_ready  (host_ready),
    .host_rvalid (host_rvalid),
    .host_rprob  (host_rprob),
    .mem         (host_bus)
  );

  range_encoder u_encoder (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (enc_valid),
    .in_sym    (enc_sym),
    .in_prob   (enc_prob),
    .in_ready  (enc_ready),
    .out_byte  (out_byte),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

// ==== design/range_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bin_coder_consts.svh"

module range_encoder (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  logic                   in_sym,
  input  coder_types_pkg::prob_t in_prob,
  output logic                   in_ready,
  output coder_types_pkg::byte_t out_byte,
  output logic                   out_valid,
  input  logic                   out_ready
);

  coder_types_pkg::encoder_state_t state_q;
  coder_types_pkg::coder_word_t    low_q;
  coder_types_pkg::coder_word_t    range_q;

  logic [`WORD_BITS+`PROB_BITS-1:0] prod; // full range * p
  coder_types_pkg::coder_word_t     split;
  logic                             need_byte; // range too small
  logic                             slot_free; // output register can load

  // split = (range * p) >> 12, both operands widened first
  assign prod  = {{`PROB_BITS{1'b0}}, range_q} * {{`WORD_BITS{1'b0}}, in_prob};
  assign split = prod[`WORD_BITS+`PROB_BITS-1:`PROB_BITS];

  assign need_byte = (range_q < `RENORM_MIN);
  assign slot_free = !out_valid || out_ready; // empty, or current byte leaves now

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= coder_types_pkg::ENC_IDLE;
      low_q     <= '0;
      range_q   <= '1; // full interval
      out_valid <= 1'b0;
    end else begin
      if (out_valid && out_ready) out_valid <= 1'b0; // byte taken

      case (state_q)
        coder_types_pkg::ENC_IDLE: begin
          if (in_valid) begin
            if (in_sym) begin
              low_q   <= low_q + (range_q - split); // carry out is dropped
              range_q <= split;
            end else begin
              range_q <= range_q - split;
            end
            state_q <= coder_types_pkg::ENC_RENORM;
          end
        end

        coder_types_pkg::ENC_RENORM: begin
          if (!need_byte) begin
            state_q <= coder_types_pkg::ENC_IDLE; // interval wide enough again
          end else if (slot_free) begin
            out_valid <= 1'b1;
            low_q     <= low_q << 8;
            range_q   <= range_q << 8;
          end
          // otherwise sit here with the byte held
        end

        default: state_q <= coder_types_pkg::ENC_IDLE;
      endcase
    end
  end

  // byte payload, only loaded as a step shifts it out
  always_ff @(posedge clk) begin
    if (state_q == coder_types_pkg::ENC_RENORM && need_byte && slot_free) begin
      out_byte <= low_q[`WORD_BITS-1:`WORD_BITS-`BYTE_BITS]; // top byte of low
    end
  end

  // taking a new symbol only while idle keeps bytes in order
  assign in_ready = (state_q == coder_types_pkg::ENC_IDLE);

endmodule

`default_nettype wire

// ==== design/ctx_host_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctx_host_port (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      host_valid,
  input  logic                      host_write,
  input  coder_types_pkg::ctx_idx_t host_ctx,
  input  coder_types_pkg::prob_t    host_wprob,
  output logic                      host_ready,
  output logic                      host_rvalid,
  output coder_types_pkg::prob_t    host_rprob,
  ctx_mem_if.requester              mem
);

  logic                      req_q;   // memory request pending
  logic                      wait_q;  // read granted, data due
  logic                      write_q; // captured request
  coder_types_pkg::ctx_idx_t ctx_q;
  coder_types_pkg::prob_t    wprob_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q       <= 1'b0;
      wait_q      <= 1'b0;
      host_rvalid <= 1'b0;
    end else begin
      host_rvalid <= mem.rvalid; // single pulse per read
      if (host_valid && host_ready) req_q <= 1'b1;
      else if (mem.gnt) begin
        req_q  <= 1'b0;
        wait_q <= !write_q; // writes finish at the grant
      end
      if (mem.rvalid) wait_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (host_valid && host_ready) begin
      write_q <= host_write;
      ctx_q   <= host_ctx;
      wprob_q <= host_wprob;
    end
    if (mem.rvalid) host_rprob <= mem.rdata;
  end

  assign host_ready = !(req_q || wait_q);

  assign mem.req   = req_q;
  assign mem.we    = write_q;
  assign mem.addr  = ctx_q;
  assign mem.wdata = wprob_q;

endmodule

`default_nettype wire

// ==== design/ctx_modeler.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bin_coder_consts.svh"

module ctx_modeler (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      bin_valid,
  input  logic                      bin_sym,
  input  coder_types_pkg::ctx_idx_t bin_ctx,
  output logic                      bin_ready,
  ctx_mem_if.requester              mem,
  output logic                      enc_valid,
  output logic                      enc_sym,
  output coder_types_pkg::prob_t    enc_prob,
  input  logic                      enc_ready
);

  // one extra bit so 4096 - p fits
  localparam logic [`PROB_BITS:0] PROB_ONE = 1 << `PROB_BITS;

  coder_types_pkg::modeler_state_t state_q;
  logic                      sym_q;   // latched bin
  coder_types_pkg::ctx_idx_t ctx_q;
  coder_types_pkg::prob_t    prob_q;  // value as looked up
  coder_types_pkg::prob_t    adapt_q; // value to write back

  logic [`PROB_BITS:0] p_ext;
  logic [`PROB_BITS:0] p_up;   // after a one
  logic [`PROB_BITS:0] p_dn;   // after a zero
  logic [`PROB_BITS:0] p_next; // before clamping
  coder_types_pkg::prob_t p_clamped;

  // adapt straight off the read data so it can be stored with it
  always_comb begin
    p_ext  = {1'b0, mem.rdata};
    p_up   = p_ext + ((PROB_ONE - p_ext) >> `ADAPT_SHIFT);
    p_dn   = p_ext - (p_ext >> `ADAPT_SHIFT);
    p_next = sym_q ? p_up : p_dn;
    if (p_next < {1'b0, `PROB_MIN}) p_clamped = `PROB_MIN;
    else if (p_next > {1'b0, `PROB_MAX}) p_clamped = `PROB_MAX;
    else p_clamped = p_next[`PROB_BITS-1:0];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= coder_types_pkg::MDL_IDLE;
    end else begin
      case (state_q)
        coder_types_pkg::MDL_IDLE:
          if (bin_valid) state_q <= coder_types_pkg::MDL_READ;
        coder_types_pkg::MDL_READ:
          if (mem.gnt) state_q <= coder_types_pkg::MDL_WAIT; // may lose to nobody, host waits
        coder_types_pkg::MDL_WAIT:
          if (mem.rvalid) state_q <= coder_types_pkg::MDL_WRITE;
        coder_types_pkg::MDL_WRITE:
          if (mem.gnt) state_q <= coder_types_pkg::MDL_SEND;
        coder_types_pkg::MDL_SEND:
          if (enc_ready) state_q <= coder_types_pkg::MDL_IDLE;
        default: state_q <= coder_types_pkg::MDL_IDLE;
      endcase
    end
  end

  // bin and probability payload
  always_ff @(posedge clk) begin
    if (bin_valid && bin_ready) begin
      sym_q <= bin_sym;
      ctx_q <= bin_ctx;
    end
    if (state_q == coder_types_pkg::MDL_WAIT && mem.rvalid) begin
      prob_q  <= mem.rdata; // encoder codes with the old value
      adapt_q <= p_clamped;
    end
  end

  assign bin_ready = (state_q == coder_types_pkg::MDL_IDLE); // one bin in flight

  assign mem.req   = (state_q == coder_types_pkg::MDL_READ) ||
                     (state_q == coder_types_pkg::MDL_WRITE);
  assign mem.we    = (state_q == coder_types_pkg::MDL_WRITE);
  assign mem.addr  = ctx_q;
  assign mem.wdata = adapt_q;

  assign enc_valid = (state_q == coder_types_pkg::MDL_SEND);
  assign enc_sym   = sym_q;
  assign enc_prob  = prob_q;

endmodule

`default_nettype wire

// ==== design/ctx_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bin_coder_consts.svh"

module ctx_store (
  input  logic         clk,
  input  logic         rst_n,
  ctx_mem_if.store     mdl,  // higher priority
  ctx_mem_if.store     host
);

  ctx_mem_pkg::mem_data_t mem [`CTX_COUNT]; // contents undefined until loaded

  ctx_mem_pkg::grant_t    sel;     // winner this cycle
  ctx_mem_pkg::grant_t    owner_q; // read owner of last cycle
  logic                   sel_we;
  ctx_mem_pkg::mem_addr_t sel_addr;
  ctx_mem_pkg::mem_data_t sel_wdata;
  ctx_mem_pkg::mem_data_t rdata_q;

  // fixed priority, modeler first
  always_comb begin
    if (mdl.req) sel = ctx_mem_pkg::GNT_MODELER;
    else if (host.req) sel = ctx_mem_pkg::GNT_HOST;
    else sel = ctx_mem_pkg::GNT_NONE;
  end

  // steer the winner onto the single memory port
  always_comb begin
    case (sel)
      ctx_mem_pkg::GNT_MODELER: begin
        sel_we    = mdl.we;
        sel_addr  = mdl.addr;
        sel_wdata = mdl.wdata;
      end
      ctx_mem_pkg::GNT_HOST: begin
        sel_we    = host.we;
        sel_addr  = host.addr;
        sel_wdata = host.wdata;
      end
      default: begin
        sel_we    = 1'b0; // idle port never writes
        sel_addr  = mdl.addr;
        sel_wdata = mdl.wdata;
      end
    endcase
  end

  assign mdl.gnt  = (sel == ctx_mem_pkg::GNT_MODELER);
  assign host.gnt = (sel == ctx_mem_pkg::GNT_HOST);

  always_ff @(posedge clk) begin
    if (sel != ctx_mem_pkg::GNT_NONE) begin
      if (sel_we) mem[sel_addr] <= sel_wdata; // write lands at the gnt edge
      else rdata_q <= mem[sel_addr];
    end
  end

  // remember who gets the read data next cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner_q <= ctx_mem_pkg::GNT_NONE;
    end else begin
      owner_q <= sel_we ? ctx_mem_pkg::GNT_NONE : sel;
    end
  end

  assign mdl.rdata   = rdata_q; // shared, rvalid tells who it is for
  assign host.rdata  = rdata_q;
  assign mdl.rvalid  = (owner_q == ctx_mem_pkg::GNT_MODELER);
  assign host.rvalid = (owner_q == ctx_mem_pkg::GNT_HOST);

endmodule

`default_nettype wire

// ==== design/ctx_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one requester's path into the shared context memory
interface ctx_mem_if;

  logic                  req;    // held until gnt
  logic                  we;     // 1 write, 0 read
  ctx_mem_pkg::mem_addr_t addr;
  ctx_mem_pkg::mem_data_t wdata;
  logic                  gnt;    // request taken this cycle
  ctx_mem_pkg::mem_data_t rdata; // good while rvalid
  logic                  rvalid; // one cycle after a read gnt

  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata, rvalid
  );

  modport store (
    input  req, we, addr, wdata,
    output gnt, rdata, rvalid
  );

endinterface

`default_nettype wire

// ==== design/ctx_mem_pkg.sv ====
`default_nettype none

`include "bin_coder_consts.svh"

package ctx_mem_pkg;

  typedef logic [`CTX_BITS-1:0]  mem_addr_t; // one word per context
  typedef logic [`PROB_BITS-1:0] mem_data_t; // stored probability

  // who owns the memory port this cycle
  typedef enum logic [1:0] {
    GNT_NONE     = 2'd0,
    GNT_MODELER  = 2'd1, // wins every tie
    GNT_HOST     = 2'd2
  } grant_t;

endpackage

`default_nettype wire

// ==== design/coder_types_pkg.sv ====
`default_nettype none

`include "bin_coder_consts.svh"

package coder_types_pkg;

  typedef logic [`PROB_BITS-1:0] prob_t;       // p(one) * 4096
  typedef logic [`CTX_BITS-1:0]  ctx_idx_t;    // context number
  typedef logic [`BYTE_BITS-1:0] byte_t;       // coded output byte
  typedef logic [`WORD_BITS-1:0] coder_word_t; // low / range

  // modeler walks one bin at a time through these
  typedef enum logic [2:0] {
    MDL_IDLE  = 3'd0, // waiting for a bin
    MDL_READ  = 3'd1, // read request out
    MDL_WAIT  = 3'd2, // read granted, data next cycle
    MDL_WRITE = 3'd3, // adapted value going back
    MDL_SEND  = 3'd4  // offering sym + prob to the encoder
  } modeler_state_t;

  typedef enum logic {
    ENC_IDLE   = 1'b0, // ready for a symbol
    ENC_RENORM = 1'b1  // shifting out bytes
  } encoder_state_t;

endpackage

`default_nettype wire

// ==== design/bin_coder_consts.svh ====
`ifndef BIN_CODER_CONSTS_SVH
`define BIN_CODER_CONSTS_SVH

// probability of a one, in units of 1/4096
`define PROB_BITS 12

// context table geometry
`define CTX_COUNT 64
`define CTX_BITS 6

// coder datapath widths
`define WORD_BITS 32 // low and range
`define BYTE_BITS 8  // one coded output byte

`define RENORM_MIN 32'h0100_0000 // range below this emits a byte
`define ADAPT_SHIFT 5            // adaptation rate, larger is slower

`define PROB_MIN 12'd32   // lowest adapted probability
`define PROB_MAX 12'd4064 // highest adapted probability

`endif
